// ==== project.f ====
source/aesPkg.sv
source/axiLitePkg.sv
source/aesControl.sv
source/aesKeySchedule.sv
source/aesInvRound.sv
source/aesRegSlave.sv
source/aesDecryptTop.sv
verification/aesDecryptTb.sv

// ==== source/aesControl.sv ====
`timescale 1ns/1ps

module aesControl
(
	input  logic             Clk,
	input  logic             arstN,
	input  logic             start,
	output aesPkg::aesCtrl_t ctrl,
	output logic             done
);
	import aesPkg::*;

	typedef enum logic [3:0]
	{
		stIdle,
		stKey1,
		stKey2,
		stKey3,
		stKey4,
		stKey5,
		stKey6,
		stKey7,
		stKey8,
		stKey9,
		stKey10,
		stAddKey,
		stInvShift,
		stInvSub,
		stInvMix,
		stDone
	} ctrlState_t;

	ctrlState_t state;
	ctrlState_t nextState;
	aesRound_t  round;      // Counts 10 down to 0
	aesRound_t  nextRound;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
			round <= '0;
		end
		else
		begin
			state <= nextState;
			round <= nextRound;
		end
	end

	always_comb
	begin
		nextState = state;
		nextRound = round;
		unique case (state)
			stIdle:
			begin
				if (start)
				begin
					nextState = stKey1;
					nextRound = aesRound_t'(numRounds);
				end
			end
			stKey1:     nextState = stKey2;
			stKey2:     nextState = stKey3;
			stKey3:     nextState = stKey4;
			stKey4:     nextState = stKey5;
			stKey5:     nextState = stKey6;
			stKey6:     nextState = stKey7;
			stKey7:     nextState = stKey8;
			stKey8:     nextState = stKey9;
			stKey9:     nextState = stKey10;
			stKey10:    nextState = stAddKey;
			stAddKey:
			begin
				if (round == aesRound_t'(numRounds))
					nextState = stInvShift;  // Initial key add, no mix columns
				else if (round == '0)
					nextState = stDone;
				else
					nextState = stInvMix;
				if (round != '0)
					nextRound = round - 4'd1;
			end
			stInvShift: nextState = stInvSub;
			stInvSub:   nextState = stAddKey;
			stInvMix:   nextState = stInvShift;
			stDone:
			begin
				if (!start)
					nextState = stIdle;
			end
		endcase
	end

	always_comb
	begin
		ctrl = '{load: 1'b0, keyStep: 1'b0, opEn: 1'b0, op: addKey, round: round};
		done = 1'b0;
		case (state)
			stIdle:     ctrl.load = start;
			stKey1, stKey2, stKey3, stKey4, stKey5,
			stKey6, stKey7, stKey8, stKey9, stKey10:
				ctrl.keyStep = 1'b1;
			stAddKey:   ctrl.opEn = 1'b1;
			stInvShift:
			begin
				ctrl.opEn = 1'b1;
				ctrl.op   = invShiftRows;
			end
			stInvSub:
			begin
				ctrl.opEn = 1'b1;
				ctrl.op   = invSubBytes;
			end
			stInvMix:
			begin
				ctrl.opEn = 1'b1;
				ctrl.op   = invMixCols;
			end
			stDone:     done = 1'b1;
			default: ;
		endcase
	end

	roundInRange: assert property (@(posedge Clk) disable iff (!arstN)
		ctrl.round <= numRounds);

	// Key schedule finishes before the datapath touches the state
	keysBeforeOps: assert property (@(posedge Clk) disable iff (!arstN)
		ctrl.load |=> (ctrl.keyStep && !ctrl.opEn) [*10]
		##1 (ctrl.opEn && ctrl.op == addKey && ctrl.round == numRounds));

	doneLatency: assert property (@(posedge Clk) disable iff (!arstN)
		ctrl.load |=> !done [*50] ##1 done);

endmodule

// ==== source/aesDecryptTop.sv ====
`timescale 1ns/1ps

module aesDecryptTop
(
	input  logic                    Clk,
	input  logic                    arstN,
	input  axiLitePkg::axiLiteReq_t axiReq,
	output axiLitePkg::axiLiteRsp_t axiRsp
);
	import aesPkg::*;

	logic      start;
	logic      done;
	aesBlock_t key;
	aesBlock_t cipherText;
	aesBlock_t roundKey;
	aesBlock_t plainText;
	aesCtrl_t  ctrl;

	aesRegSlave regSlave_i
	(
		.Clk        (Clk),
		.arstN      (arstN),
		.axiReq     (axiReq),
		.axiRsp     (axiRsp),
		.done       (done),
		.plainText  (plainText),
		.start      (start),
		.key        (key),
		.cipherText (cipherText)
	);

	aesControl control_i
	(
		.Clk   (Clk),
		.arstN (arstN),
		.start (start),
		.ctrl  (ctrl),
		.done  (done)
	);

	aesKeySchedule keySchedule_i
	(
		.Clk      (Clk),
		.arstN    (arstN),
		.ctrl     (ctrl),
		.key      (key),
		.roundKey (roundKey)
	);

	aesInvRound invRound_i
	(
		.Clk        (Clk),
		.arstN      (arstN),
		.ctrl       (ctrl),
		.cipherText (cipherText),
		.roundKey   (roundKey),
		.plainText  (plainText)
	);

endmodule

// ==== source/aesInvRound.sv ====
`timescale 1ns/1ps

module aesInvRound
(
	input  logic              Clk,
	input  logic              arstN,
	input  aesPkg::aesCtrl_t  ctrl,
	input  aesPkg::aesBlock_t cipherText,
	input  aesPkg::aesBlock_t roundKey,
	output aesPkg::aesBlock_t plainText
);
	import aesPkg::*;

	aesBlock_t stateReg;
	aesBlock_t opResult;

	function automatic aesByte_t getByte(aesBlock_t s, int idx);
		return s[127 - 8 * idx -: 8];
	endfunction

	// Row r moves right by r columns
	function automatic aesBlock_t doInvShift(aesBlock_t s);
		aesBlock_t res;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				res[127 - 8 * (4 * c + r) -: 8] = getByte(s, 4 * ((c - r + 4) % 4) + r);
		return res;
	endfunction

	function automatic aesBlock_t doInvSub(aesBlock_t s);
		aesBlock_t res;
		for (int i = 0; i < 16; i++)
			res[127 - 8 * i -: 8] = invSbox(getByte(s, i));
		return res;
	endfunction

	function automatic aesBlock_t doInvMix(aesBlock_t s);
		aesBlock_t res;
		aesByte_t  col [4];
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
				col[r] = getByte(s, 4 * c + r);
			for (int r = 0; r < 4; r++)
				res[127 - 8 * (4 * c + r) -: 8] = gfMul(col[r], 8'h0e)
					^ gfMul(col[(r + 1) % 4], 8'h0b)
					^ gfMul(col[(r + 2) % 4], 8'h0d)
					^ gfMul(col[(r + 3) % 4], 8'h09);
		end
		return res;
	endfunction

	// ****************************
	// Operation select
	// ****************************
	always_comb
	begin
		unique case (ctrl.op)
			addKey:       opResult = stateReg ^ roundKey;
			invShiftRows: opResult = doInvShift(stateReg);
			invSubBytes:  opResult = doInvSub(stateReg);
			invMixCols:   opResult = doInvMix(stateReg);
		endcase
	end

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			stateReg <= '0;
		else if (ctrl.load)
			stateReg <= cipherText;
		else if (ctrl.opEn)
			stateReg <= opResult;
	end

	assign plainText = stateReg;

endmodule

// ==== source/aesKeySchedule.sv ====
`timescale 1ns/1ps

module aesKeySchedule
(
	input  logic              Clk,
	input  logic              arstN,
	input  aesPkg::aesCtrl_t  ctrl,
	input  aesPkg::aesBlock_t key,
	output aesPkg::aesBlock_t roundKey
);
	import aesPkg::*;

	aesBlock_t keyMem [numRounds + 1];
	aesRound_t stepIdx;  // Index of last written round key
	aesByte_t  rcon;
	aesBlock_t prevKey;
	aesBlock_t nextKey;
	aesWord_t  subRot;

	// ****************************
	// Next round key
	// ****************************
	always_comb
	begin
		prevKey = keyMem[stepIdx];
		subRot  = {sbox(prevKey[23:16]), sbox(prevKey[15:8]),
			sbox(prevKey[7:0]), sbox(prevKey[31:24])};  // SubWord(RotWord(w3))
		nextKey[127:96] = prevKey[127:96] ^ subRot ^ {rcon, 24'h000000};
		nextKey[95:64]  = prevKey[95:64] ^ nextKey[127:96];
		nextKey[63:32]  = prevKey[63:32] ^ nextKey[95:64];
		nextKey[31:0]   = prevKey[31:0] ^ nextKey[63:32];
	end

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			stepIdx <= '0;
			rcon    <= 8'h01;
		end
		else if (ctrl.load)
		begin
			stepIdx <= '0;
			rcon    <= 8'h01;
		end
		else if (ctrl.keyStep)
		begin
			stepIdx <= stepIdx + 4'd1;
			rcon    <= gfMul(rcon, 8'h02);  // 01 02 04 .. 80 1b 36
		end
	end

	// Round key storage
	always_ff @(posedge Clk)
	begin
		if (ctrl.load)
			keyMem[0] <= key;
		else if (ctrl.keyStep)
			keyMem[stepIdx + 4'd1] <= nextKey;
	end

	assign roundKey = keyMem[ctrl.round];

endmodule

// ==== source/aesPkg.sv ====
package aesPkg;

	localparam int numRounds = 10;

	typedef logic [127:0] aesBlock_t;  // Byte 0 in bits 127:120, column-major
	typedef logic [31:0]  aesWord_t;
	typedef logic [7:0]   aesByte_t;
	typedef logic [3:0]   aesRound_t;

	// Encoding follows the datapath select order
	typedef enum logic [1:0]
	{
		addKey       = 2'b00,
		invShiftRows = 2'b01,
		invSubBytes  = 2'b10,
		invMixCols   = 2'b11
	} aesOp_t;

	typedef struct packed
	{
		logic      load;     // Capture key and ciphertext
		logic      keyStep;  // Expand next round key
		logic      opEn;
		aesOp_t    op;
		aesRound_t round;
	} aesCtrl_t;

	// ****************************
	// GF(2^8) arithmetic
	// ****************************

	function automatic aesByte_t gfMul(aesByte_t a, aesByte_t b);
		aesByte_t acc;
		aesByte_t sh;
		acc = '0;
		sh  = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				acc = acc ^ sh;
			sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);  // Reduce by x^8+x^4+x^3+x+1
		end
		return acc;
	endfunction

	// Multiplicative inverse as a^254, zero maps to zero
	function automatic aesByte_t gfInv(aesByte_t a);
		aesByte_t acc;
		aesByte_t sq;
		acc = 8'h01;
		sq  = a;
		for (int i = 1; i < 8; i++)
		begin
			sq  = gfMul(sq, sq);
			acc = gfMul(acc, sq);
		end
		return acc;
	endfunction

	function automatic aesByte_t rotl8(aesByte_t a, int n);
		return aesByte_t'((a << n) | (a >> (8 - n)));
	endfunction

	function automatic aesByte_t sbox(aesByte_t a);
		aesByte_t b;
		b = gfInv(a);
		return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
	endfunction

	// Undo the affine map first, then invert
	function automatic aesByte_t invSbox(aesByte_t a);
		return gfInv(rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05);
	endfunction

endpackage

// ==== source/aesRegSlave.sv ====
`timescale 1ns/1ps

module aesRegSlave
(
	input  logic                    Clk,
	input  logic                    arstN,
	input  axiLitePkg::axiLiteReq_t axiReq,
	output axiLitePkg::axiLiteRsp_t axiRsp,
	input  logic                    done,
	input  aesPkg::aesBlock_t       plainText,
	output logic                    start,
	output aesPkg::aesBlock_t       key,
	output aesPkg::aesBlock_t       cipherText
);
	import aesPkg::*;
	import axiLitePkg::*;

	logic       wrAccept;  // Drives awReady and wReady
	logic       bValid;
	axiResp_t   bResp;
	logic       arReady;
	logic       rValid;
	axiData_t   rData;
	axiResp_t   rResp;
	logic       busy;
	logic [1:0] wrIdx;
	logic [1:0] rdIdx;
	axiData_t   rdWord;
	logic       rdHit;

	function automatic logic inBank(axiAddr_t addr, axiAddr_t base);
		return addr[7:4] == base[7:4] && addr[1:0] == 2'b00;
	endfunction

	function automatic axiData_t getWord(aesBlock_t blk, logic [1:0] idx);
		return blk[127 - 32 * idx -: 32];
	endfunction

	function automatic axiData_t mergeBytes(axiData_t old, axiData_t data, axiStrb_t strb);
		axiData_t res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				res[8 * b +: 8] = data[8 * b +: 8];
		return res;
	endfunction

	assign busy  = start && !done;
	assign wrIdx = axiReq.awAddr[3:2];
	assign rdIdx = axiReq.arAddr[3:2];

	// ****************************
	// Write channel
	// ****************************
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrAccept   <= 1'b0;
			bValid     <= 1'b0;
			bResp      <= respOkay;
			start      <= 1'b0;
			key        <= '0;
			cipherText <= '0;
		end
		else
		begin
			wrAccept <= axiReq.awValid && axiReq.wValid && !wrAccept && !bValid;
			if (wrAccept)
			begin
				bValid <= 1'b1;
				bResp  <= respOkay;
				if (inBank(axiReq.awAddr, regKey0))
					key[127 - 32 * wrIdx -: 32] <=
						mergeBytes(getWord(key, wrIdx), axiReq.wData, axiReq.wStrb);
				else if (inBank(axiReq.awAddr, regCipher0))
					cipherText[127 - 32 * wrIdx -: 32] <=
						mergeBytes(getWord(cipherText, wrIdx), axiReq.wData, axiReq.wStrb);
				else if (axiReq.awAddr == regCtrl)
				begin
					if (axiReq.wStrb[0])
						start <= axiReq.wData[0];
				end
				else
					bResp <= respSlvErr;  // Status, plaintext and holes
			end
			else if (bValid && axiReq.bReady)
				bValid <= 1'b0;
		end
	end

	// ****************************
	// Read channel
	// ****************************
	always_comb
	begin
		rdHit  = 1'b1;
		rdWord = '0;
		if (axiReq.arAddr == regCtrl)
			rdWord = {31'b0, start};
		else if (axiReq.arAddr == regStatus)
			rdWord = {30'b0, busy, done};
		else if (inBank(axiReq.arAddr, regKey0))
			rdWord = getWord(key, rdIdx);
		else if (inBank(axiReq.arAddr, regCipher0))
			rdWord = getWord(cipherText, rdIdx);
		else if (inBank(axiReq.arAddr, regPlain0))
			rdWord = getWord(plainText, rdIdx);
		else
			rdHit = 1'b0;
	end

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			arReady <= 1'b0;
			rValid  <= 1'b0;
			rData   <= '0;
			rResp   <= respOkay;
		end
		else
		begin
			arReady <= axiReq.arValid && !arReady && !rValid;
			if (arReady)
			begin
				rValid <= 1'b1;
				rData  <= rdWord;
				rResp  <= rdHit ? respOkay : respSlvErr;
			end
			else if (rValid && axiReq.rReady)
				rValid <= 1'b0;
		end
	end

	assign axiRsp = '{
		awReady: wrAccept,
		wReady:  wrAccept,
		bResp:   bResp,
		bValid:  bValid,
		arReady: arReady,
		rData:   rData,
		rResp:   rResp,
		rValid:  rValid
	};

	bHeld: assert property (@(posedge Clk) disable iff (!arstN)
		bValid && !axiReq.bReady |=> bValid && $stable(bResp));

	rHeld: assert property (@(posedge Clk) disable iff (!arstN)
		rValid && !axiReq.rReady |=> rValid && $stable(rData) && $stable(rResp));

endmodule

// ==== source/axiLitePkg.sv ====
package axiLitePkg;

	typedef logic [7:0]  axiAddr_t;
	typedef logic [31:0] axiData_t;
	typedef logic [3:0]  axiStrb_t;

	typedef enum logic [1:0]
	{
		respOkay   = 2'b00,
		respSlvErr = 2'b10
	} axiResp_t;

	typedef struct packed
	{
		axiAddr_t awAddr;
		logic     awValid;
		axiData_t wData;
		axiStrb_t wStrb;
		logic     wValid;
		logic     bReady;
		axiAddr_t arAddr;
		logic     arValid;
		logic     rReady;
	} axiLiteReq_t;

	typedef struct packed
	{
		logic     awReady;
		logic     wReady;
		axiResp_t bResp;
		logic     bValid;
		logic     arReady;
		axiData_t rData;
		axiResp_t rResp;
		logic     rValid;
	} axiLiteRsp_t;

	// ****************************
	// Register map
	// ****************************
	localparam axiAddr_t regCtrl    = 8'h00;  // Bit 0 start
	localparam axiAddr_t regStatus  = 8'h04;  // Bit 0 done, bit 1 busy
	localparam axiAddr_t regKey0    = 8'h10;  // Word 0 holds block bits 127:96
	localparam axiAddr_t regCipher0 = 8'h20;
	localparam axiAddr_t regPlain0  = 8'h30;

endpackage

// ==== verification/aesDecryptTb.sv ====
`timescale 1ns/1ps

module aesDecryptTb;
	import aesPkg::*;
	import axiLitePkg::*;

	logic              Clk = 1'b0;
	logic              arstN;
	axiLiteReq_t       axiReq;
	axiLiteRsp_t       axiRsp;

	aesBlock_t         keyList [$];
	aesBlock_t         cipherList [$];
	aesBlock_t         plainList [$];
	aesBlock_t         vKey;
	aesBlock_t         vCipher;
	aesBlock_t         vPlain;
	logic [8*160-1:0]  line;
	int                fd;
	axiData_t          data;
	axiResp_t          resp;
	axiAddr_t          badAddr [3] = '{8'h08, 8'h40, 8'hfc};
	integer            seed = 76338;
	int                cycleCount = 0;
	int                cycleLimit = 0;
	int                checks = 0;
	int                mismatches = 0;
	int                failures = 0;

	aesDecryptTop dut_i
	(
		.Clk    (Clk),
		.arstN  (arstN),
		.axiReq (axiReq),
		.axiRsp (axiRsp)
	);

	always #20 Clk = ~Clk;

	always @(posedge Clk)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("the run did not finish within %0d cycles", cycleLimit);
			$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ****************************
	// AXI4-Lite host
	// ****************************
	task automatic compareWord(input string name, input axiData_t got, input axiData_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic backPressure();
		int idle;
		idle = $unsigned($random(seed)) % 4;
		repeat (idle) @(posedge Clk);
	endtask

	task automatic writeReg(input axiAddr_t addr, input axiData_t wr, input axiStrb_t strb,
		output axiResp_t rsp);
		@(posedge Clk);
		axiReq.awAddr  <= addr;
		axiReq.awValid <= 1'b1;
		axiReq.wData   <= wr;
		axiReq.wStrb   <= strb;
		axiReq.wValid  <= 1'b1;
		do
			@(negedge Clk);
		while (!axiRsp.awReady);
		compareWord("wReady with awReady", axiRsp.wReady, 32'h1);
		@(posedge Clk);  // Handshake edge
		axiReq.awValid <= 1'b0;
		axiReq.wValid  <= 1'b0;
		backPressure();
		axiReq.bReady <= 1'b1;
		do
			@(negedge Clk);
		while (!axiRsp.bValid);
		rsp = axiRsp.bResp;
		@(posedge Clk);
		axiReq.bReady <= 1'b0;
	endtask

	task automatic readReg(input axiAddr_t addr, output axiData_t rd, output axiResp_t rsp);
		@(posedge Clk);
		axiReq.arAddr  <= addr;
		axiReq.arValid <= 1'b1;
		do
			@(negedge Clk);
		while (!axiRsp.arReady);
		@(posedge Clk);
		axiReq.arValid <= 1'b0;
		backPressure();
		axiReq.rReady <= 1'b1;
		do
			@(negedge Clk);
		while (!axiRsp.rValid);
		rd  = axiRsp.rData;
		rsp = axiRsp.rResp;
		@(posedge Clk);
		axiReq.rReady <= 1'b0;
	endtask

	task automatic writeOk(input axiAddr_t addr, input axiData_t wr, input axiStrb_t strb);
		axiResp_t rsp;
		writeReg(addr, wr, strb, rsp);
		compareWord($sformatf("bResp at %h", addr), rsp, respOkay);
	endtask

	task automatic readOk(input axiAddr_t addr, output axiData_t rd);
		axiResp_t rsp;
		readReg(addr, rd, rsp);
		compareWord($sformatf("rResp at %h", addr), rsp, respOkay);
	endtask

	task automatic writeBlock(input axiAddr_t base, input aesBlock_t blk);
		for (int i = 0; i < 4; i++)
			writeOk(axiAddr_t'(base + 4 * i), blk[127 - 32 * i -: 32], 4'hf);
	endtask

	task automatic checkBlock(input axiAddr_t base, input aesBlock_t exp, input string name);
		axiData_t rd;
		for (int i = 0; i < 4; i++)
		begin
			readOk(axiAddr_t'(base + 4 * i), rd);
			compareWord($sformatf("%s word %0d", name, i), rd, exp[127 - 32 * i -: 32]);
		end
	endtask

	// ****************************
	// Run control
	// ****************************
	task automatic waitDone();
		axiData_t status;
		status = '0;
		while (!status[0])
		begin
			readOk(regStatus, status);
			if (!status[0])
				compareWord("status while running", status, 32'h2);  // Busy only
		end
		compareWord("status at done", status, 32'h1);
	endtask

	task automatic finishRun();
		axiData_t status;
		readOk(regStatus, status);
		compareWord("status with start held", status, 32'h1);
		writeOk(regCtrl, 32'h0, 4'h1);
		readOk(regStatus, status);
		compareWord("status after start cleared", status, 32'h0);
	endtask

	task automatic decryptVector(input int idx);
		writeBlock(regKey0, keyList[idx]);
		writeBlock(regCipher0, cipherList[idx]);
		writeOk(regCtrl, 32'h1, 4'h1);
		waitDone();
		checkBlock(regPlain0, plainList[idx], $sformatf("plainText test %0d", idx));
		finishRun();
	endtask

	initial
	begin
		arstN  = 1'b0;
		axiReq = '0;
		fd = $fopen("verification/aesTests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test vector file");
			failures++;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
				if ($sscanf(line, "%h %h %h", vKey, vCipher, vPlain) == 3)  // Skips comments
				begin
					keyList.push_back(vKey);
					cipherList.push_back(vCipher);
					plainList.push_back(vPlain);
				end
			$fclose(fd);
		end
		if (keyList.size() == 0)
		begin
			$display("no test vectors were read");
			failures++;
		end
		cycleLimit = keyList.size() * 400 + 200;
		repeat (3) @(posedge Clk);
		arstN <= 1'b1;

		readOk(regStatus, data);
		compareWord("status after reset", data, 32'h0);
		checkBlock(regKey0, '0, "key after reset");

		// Byte strobes merge into the old word
		writeOk(regKey0, 32'h11223344, 4'hf);
		writeOk(regKey0, 32'haabbccdd, 4'b0101);
		readOk(regKey0, data);
		compareWord("key word 0", data, 32'h11bb33dd);
		writeOk(regCipher0 + 8'h0c, 32'h01020304, 4'hf);
		writeOk(regCipher0 + 8'h0c, 32'hf0e0d0c0, 4'b1000);
		readOk(regCipher0 + 8'h0c, data);
		compareWord("cipherText word 3", data, 32'hf0020304);
		writeBlock(regKey0, 128'h00112233_44556677_8899aabb_ccddeeff);
		writeBlock(regCipher0, 128'hfedcba98_76543210_0f1e2d3c_4b5a6978);
		checkBlock(regKey0, 128'h00112233_44556677_8899aabb_ccddeeff, "key");
		checkBlock(regCipher0, 128'hfedcba98_76543210_0f1e2d3c_4b5a6978, "cipherText");

		// ****************************
		// Unmapped and read-only addresses
		// ****************************
		writeReg(regPlain0, 32'hffffffff, 4'hf, resp);
		compareWord("bResp at plaintext", resp, respSlvErr);
		writeReg(regStatus, 32'hffffffff, 4'hf, resp);
		compareWord("bResp at status", resp, respSlvErr);
		foreach (badAddr[i])
		begin
			writeReg(badAddr[i], 32'hffffffff, 4'hf, resp);
			compareWord($sformatf("bResp at %h", badAddr[i]), resp, respSlvErr);
			readReg(badAddr[i], data, resp);
			compareWord($sformatf("rData at %h", badAddr[i]), data, 32'h0);
			compareWord($sformatf("rResp at %h", badAddr[i]), resp, respSlvErr);
		end
		checkBlock(regKey0, 128'h00112233_44556677_8899aabb_ccddeeff, "key after bad writes");
		checkBlock(regCipher0, 128'hfedcba98_76543210_0f1e2d3c_4b5a6978, "cipherText after bad writes");
		checkBlock(regPlain0, '0, "plainText after bad writes");
		readOk(regCtrl, data);
		compareWord("control after bad writes", data, 32'h0);

		foreach (keyList[i])
			decryptVector(i);

		// New key and ciphertext written mid-run apply only to the next run
		if (keyList.size() >= 2)
		begin
			writeBlock(regKey0, keyList[0]);
			writeBlock(regCipher0, cipherList[0]);
			writeOk(regCtrl, 32'h1, 4'h1);
			writeBlock(regKey0, keyList[1]);
			writeBlock(regCipher0, cipherList[1]);
			waitDone();
			checkBlock(regPlain0, plainList[0], "plainText first capture run");
			finishRun();
			writeOk(regCtrl, 32'h1, 4'h1);
			waitDone();
			checkBlock(regPlain0, plainList[1], "plainText second capture run");
			finishRun();
		end

		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== verification/aesTests.txt ====
# key, ciphertext, expected plaintext: 32 hex digits each, byte 0 first
# Known-answer vectors from FIPS-197, SP 800-38A ECB and AESAVS
000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734
2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a
2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf ae2d8a571e03ac9c9eb76fac45af8e51
2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688 30c81c46a35ce411e5fbc1191a0a52ef
2b7e151628aed2a6abf7158809cf4f3c 7b0c785e27e8ad3f8223207104725dd4 f69f2445df4f9b17ad2b417be66c3710
00000000000000000000000000000000 0336763e966d92595a567cc9ce537f5e f34481ec3cc627bacd5dc3fb08f273e6
00000000000000000000000000000000 a9a1631bf4996954ebc093957b234589 9798c4640bad75c7c3227db910174e72
00000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34 80000000000000000000000000000000
80000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8 00000000000000000000000000000000
